//--- source/fifo_settings.svh
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// Memory address bits, depth is 2**FIFO_ADDR_WIDTH
`define FIFO_ADDR_WIDTH 4

// Bits per stored word
`define FIFO_DATA_WIDTH 8

// almost_empty while seen occupancy is below this count
`define FIFO_ALMOST_EMPTY_DIFF 4

// almost_full while seen occupancy is at least depth minus this count
`define FIFO_ALMOST_FULL_DIFF 4

`endif

//--- source/fifo_pkg.sv
`default_nettype none

`include "fifo_settings.svh"

package fifo_pkg;

    typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;  // Memory address
    typedef logic [`FIFO_ADDR_WIDTH:0]   ptr_t;   // Pointer with wrap bit, binary or Gray
    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;  // One stored word

    // Binary to Gray, one bit flips per increment
    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];  // MSB passes straight
        for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];  // Running XOR from the top
        end
        return bin;
    endfunction

endpackage

`default_nettype wire

//--- source/fifo_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_mem (
    input  wire             clk,
    input  wire             wr_en,       // Store write_data at wr_addr
    input  wire fifo_pkg::addr_t wr_addr,
    input  wire fifo_pkg::data_t write_data,
    input  wire fifo_pkg::addr_t rd_addr,     // Head of the FIFO
    output fifo_pkg::data_t read_data    // Show-ahead word
);

    localparam int depth = 1 << `FIFO_ADDR_WIDTH;  // Words in the array

    fifo_pkg::data_t mem [depth];  // Storage array

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= write_data;  // One word per accepted write
        end
    end

    // Asynchronous read port, so the head word is visible without a pop
    assign read_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- source/ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module ptr_sync (
    input  wire             clk,
    input  wire             reset_n,
    input  wire fifo_pkg::ptr_t  ptr_in,   // Gray pointer from the far side
    output fifo_pkg::ptr_t  ptr_out   // Same pointer, two edges later
);

    fifo_pkg::ptr_t stage_1;  // First flop, may go metastable with a real second clock

    // Gray coding keeps this safe, only one bit moves per pointer step
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage_1 <= '0;
            ptr_out <= '0;
        end else begin
            stage_1 <= ptr_in;   // Capture
            ptr_out <= stage_1;  // Settle
        end
    end

endmodule

`default_nettype wire

//--- source/fifo_wr_ptr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_wr_ptr (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             write,         // Push strobe, dropped while full
    input  wire fifo_pkg::ptr_t  rd_ptr_sync,   // Read pointer after sync, Gray
    output logic            wr_en,         // Memory write enable
    output fifo_pkg::addr_t wr_addr,       // Memory write address, binary
    output fifo_pkg::ptr_t  wr_ptr,        // Write pointer to the read side, Gray
    output logic            full,
    output logic            almost_full
);

    // Occupancy limits in pointer width
    localparam fifo_pkg::ptr_t depth = fifo_pkg::ptr_t'(1 << `FIFO_ADDR_WIDTH);
    localparam fifo_pkg::ptr_t almost_full_level =
        depth - fifo_pkg::ptr_t'(`FIFO_ALMOST_FULL_DIFF);

    fifo_pkg::ptr_t wr_ptr_bin;        // Current write pointer, binary
    fifo_pkg::ptr_t wr_ptr_bin_next;   // Pointer after this edge
    fifo_pkg::ptr_t wr_ptr_gray_next;  // Gray form of the next pointer
    fifo_pkg::ptr_t rd_ptr_bin;        // Synchronized read pointer, binary
    fifo_pkg::ptr_t level_next;        // Occupancy as seen from this side
    logic           full_next;
    logic           almost_full_next;

    assign wr_en = write & ~full;  // Qualify the strobe

    assign wr_ptr_bin_next  = wr_ptr_bin + fifo_pkg::ptr_t'(wr_en);
    assign wr_ptr_gray_next = fifo_pkg::bin_to_gray(wr_ptr_bin_next);
    assign rd_ptr_bin       = fifo_pkg::gray_to_bin(rd_ptr_sync);

    // Wrap bit makes the difference exact modulo twice the depth
    assign level_next = wr_ptr_bin_next - rd_ptr_bin;

    assign full_next        = (level_next == depth);              // No room left
    assign almost_full_next = (level_next >= almost_full_level);  // Near the top

    // The read pointer lags here, so the flags err toward full
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr_bin  <= '0;
            wr_ptr      <= '0;
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            wr_ptr_bin  <= wr_ptr_bin_next;
            wr_ptr      <= wr_ptr_gray_next;  // Registered Gray for the sync
            full        <= full_next;
            almost_full <= almost_full_next;
        end
    end

    assign wr_addr = wr_ptr_bin[`FIFO_ADDR_WIDTH-1:0];  // Drop the wrap bit

endmodule

`default_nettype wire

//--- source/fifo_rd_ptr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module fifo_rd_ptr (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             read,          // Pop strobe, dropped while empty
    input  wire fifo_pkg::ptr_t  wr_ptr_sync,   // Write pointer after sync, Gray
    output fifo_pkg::addr_t rd_addr,       // Memory read address, binary
    output fifo_pkg::ptr_t  rd_ptr,        // Read pointer to the write side, Gray
    output logic            empty,
    output logic            almost_empty
);

    localparam fifo_pkg::ptr_t almost_empty_level =
        fifo_pkg::ptr_t'(`FIFO_ALMOST_EMPTY_DIFF);  // Threshold in pointer width

    fifo_pkg::ptr_t rd_ptr_bin;        // Current read pointer, binary
    fifo_pkg::ptr_t rd_ptr_bin_next;   // Pointer after this edge
    fifo_pkg::ptr_t rd_ptr_gray_next;  // Gray form of the next pointer
    fifo_pkg::ptr_t wr_ptr_bin;        // Synchronized write pointer, binary
    fifo_pkg::ptr_t level_next;        // Occupancy as seen from this side
    logic           rd_en;             // Accepted pop
    logic           empty_next;
    logic           almost_empty_next;

    assign rd_en = read & ~empty;

    assign rd_ptr_bin_next  = rd_ptr_bin + fifo_pkg::ptr_t'(rd_en);
    assign rd_ptr_gray_next = fifo_pkg::bin_to_gray(rd_ptr_bin_next);
    assign wr_ptr_bin       = fifo_pkg::gray_to_bin(wr_ptr_sync);

    assign level_next = wr_ptr_bin - rd_ptr_bin_next;  // Modulo twice the depth

    // Equal Gray pointers, wrap bit included, mean nothing to read
    assign empty_next        = (rd_ptr_gray_next == wr_ptr_sync);
    assign almost_empty_next = (level_next < almost_empty_level);

    // Writes arrive late through the sync, so the flags err toward empty
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            rd_ptr_bin   <= '0;
            rd_ptr       <= '0;
            empty        <= 1'b1;  // Nothing stored after reset
            almost_empty <= 1'b1;
        end else begin
            rd_ptr_bin   <= rd_ptr_bin_next;
            rd_ptr       <= rd_ptr_gray_next;  // Registered Gray for the sync
            empty        <= empty_next;
            almost_empty <= almost_empty_next;
        end
    end

    assign rd_addr = rd_ptr_bin[`FIFO_ADDR_WIDTH-1:0];  // Head slot

endmodule

`default_nettype wire

//--- source/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module async_fifo (
    input  wire             clk,
    input  wire             reset_n,
    input  wire             write,         // Push strobe
    input  wire fifo_pkg::data_t write_data,
    input  wire             read,          // Pop strobe
    output wire             full,
    output wire             almost_full,
    output wire fifo_pkg::data_t read_data,     // Head word, valid while not empty
    output wire             empty,
    output wire             almost_empty
);

    wire             wr_en;
    wire fifo_pkg::addr_t wr_addr;
    wire fifo_pkg::addr_t rd_addr;
    wire fifo_pkg::ptr_t  wr_ptr;       // Gray, write side
    wire fifo_pkg::ptr_t  rd_ptr;       // Gray, read side
    wire fifo_pkg::ptr_t  wr_ptr_sync;  // Write pointer seen by the read side
    wire fifo_pkg::ptr_t  rd_ptr_sync;  // Read pointer seen by the write side

    fifo_mem fifo_mem_inst (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .write_data (write_data),
        .rd_addr    (rd_addr),
        .read_data  (read_data)
    );

    fifo_wr_ptr fifo_wr_ptr_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .write       (write),
        .rd_ptr_sync (rd_ptr_sync),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_ptr      (wr_ptr),
        .full        (full),
        .almost_full (almost_full)
    );

    // Write pointer into the read side
    ptr_sync wr_sync_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .ptr_in  (wr_ptr),
        .ptr_out (wr_ptr_sync)
    );

    // Read pointer into the write side
    ptr_sync rd_sync_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .ptr_in  (rd_ptr),
        .ptr_out (rd_ptr_sync)
    );

    fifo_rd_ptr fifo_rd_ptr_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .read         (read),
        .wr_ptr_sync  (wr_ptr_sync),
        .rd_addr      (rd_addr),
        .rd_ptr       (rd_ptr),
        .empty        (empty),
        .almost_empty (almost_empty)
    );

endmodule

`default_nettype wire

//--- testbench/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fifo_settings.svh"

module async_fifo_tb;

    localparam int depth          = 1 << `FIFO_ADDR_WIDTH;  // Words in the FIFO
    localparam int clk_half       = 50;                     // 100 ns period
    localparam int reset_cycles   = 2;
    localparam int random_seed    = 36;
    localparam int rounds         = 3;                      // Traffic rounds
    localparam int heavy_cycles   = 200;                    // Write-heavy or read-heavy phase
    localparam int random_cycles  = 400;
    localparam int drain_cycles   = depth + 8;              // Enough to empty a full FIFO
    localparam int gap_cycles     = 4;                      // Idle cycles before a settled check
    localparam int latency_steps  = 5;                      // One write plus four observed edges
    localparam int settled_checks = 3 + 3 * rounds;
    localparam int total_cycles   = reset_cycles + 1 + 2 * latency_steps
                                  + settled_checks * gap_cycles
                                  + rounds * (2 * heavy_cycles + random_cycles)
                                  + drain_cycles;
    localparam longint watchdog_ns = longint'(total_cycles + 100) * 2 * clk_half;

    logic            clk = 1'b0;
    logic            reset_n;
    logic            write;
    fifo_pkg::data_t write_data;
    logic            read;
    logic            full;
    logic            almost_full;
    fifo_pkg::data_t read_data;
    logic            empty;
    logic            almost_empty;

    fifo_pkg::data_t model_q[$];   // Words the FIFO should hold, head first
    int              error_count = 0;

    always #(clk_half) clk = ~clk;

    async_fifo async_fifo_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .write        (write),
        .write_data   (write_data),
        .read         (read),
        .full         (full),
        .almost_full  (almost_full),
        .read_data    (read_data),
        .empty        (empty),
        .almost_empty (almost_empty)
    );

    // Four-state compare of one value
    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED %s expected %0h actual %0h", test_name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic report_failure(input string text);
        error_count++;
        $display("ERROR %s", text);
        $display("Simulation failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Model update and flag checks at the falling edge
    task automatic sample_cycle();
        fifo_pkg::data_t head;
        int              level;
        level = model_q.size();  // Occupancy before the coming edge
        if (read && !empty) begin  // Pop at the coming edge
            assert (model_q.size() > 0) else begin
                report_failure("read accepted while the model holds no word");
            end
            head = model_q.pop_front();
            check_value("data order", head, read_data);  // Show-ahead head word
        end
        if (write && !full) begin  // Push at the coming edge
            assert (model_q.size() < depth) else begin
                report_failure("write accepted while the model already holds the full depth");
            end
            model_q.push_back(write_data);
        end
        // Flags may lag, but never claim data or room that is missing
        if (level == 0) begin
            check_value("safety empty", 1, empty);
        end
        if (level == depth) begin
            check_value("safety full", 1, full);
        end
    endtask

    // One clock cycle of stimulus
    task automatic step(input bit do_write, input bit do_read);
        @(posedge clk);
        write      <= do_write;
        write_data <= fifo_pkg::data_t'($urandom);
        read       <= do_read;
        @(negedge clk);
        sample_cycle();
    endtask

    // Rates are percentages per cycle
    task automatic run_traffic(input int cycles, input int write_pct, input int read_pct);
        bit do_write;
        bit do_read;
        for (int i = 0; i < cycles; i++) begin
            do_write = ($urandom % 100) < write_pct;
            do_read  = ($urandom % 100) < read_pct;
            step(do_write, do_read);
        end
    endtask

    // Idle long enough for both synchronizers to catch up, then compare every flag
    task automatic settled_check(input string phase_name);
        int level;
        repeat (gap_cycles) step(1'b0, 1'b0);
        level = model_q.size();
        check_value({phase_name, " empty"}, level == 0, empty);
        check_value({phase_name, " full"}, level == depth, full);
        check_value({phase_name, " almost_empty"},
                    level < `FIFO_ALMOST_EMPTY_DIFF, almost_empty);
        check_value({phase_name, " almost_full"},
                    level >= depth - `FIFO_ALMOST_FULL_DIFF, almost_full);
    endtask

    // Single write into an idle empty FIFO, empty must fall exactly 3 edges later
    task automatic latency_test(input string test_name);
        step(1'b1, 1'b0);              // Write accepted at the next edge
        for (int k = 0; k < 4; k++) begin
            step(1'b0, 1'b0);          // Edge t+k, flags observed after it
            check_value(test_name, (k < 3) ? 1 : 0, empty);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("ERROR watchdog expired, the run hung before all phases finished");
        $display("Simulation failed");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        int seed_draw;
        reset_n    = 1'b0;
        write      = 1'b0;
        read       = 1'b0;
        write_data = '0;
        seed_draw  = $urandom(random_seed);  // Seed once for the whole run

        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b1;                      // Released after two reset edges
        @(negedge clk);
        check_value("reset empty", 1, empty);
        check_value("reset almost_empty", 1, almost_empty);
        check_value("reset full", 0, full);
        check_value("reset almost_full", 0, almost_full);

        latency_test("latency after reset");
        settled_check("after first write");

        for (int r = 0; r < rounds; r++) begin
            run_traffic(heavy_cycles, 75, 25);   // Drives into full and overflow
            settled_check("write heavy");
            run_traffic(heavy_cycles, 25, 75);   // Drives into empty and underflow
            settled_check("read heavy");
            run_traffic(random_cycles, 50, 50);
            settled_check("random");
        end

        run_traffic(drain_cycles, 0, 100);       // Empty it for the last latency test
        settled_check("drain");
        latency_test("latency after drain");
        settled_check("final");

        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/fifo_pkg.sv
source/fifo_mem.sv
source/ptr_sync.sv
source/fifo_wr_ptr.sv
source/fifo_rd_ptr.sv
source/async_fifo.sv
testbench/async_fifo_tb.sv

//--- Bender.yml
package:
  name: async_fifo

sources:
  - include_dirs:
      - source
    files:
      - source/fifo_pkg.sv
      - source/fifo_mem.sv
      - source/ptr_sync.sv
      - source/fifo_wr_ptr.sv
      - source/fifo_rd_ptr.sv
      - source/async_fifo.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/async_fifo_tb.sv
